/* hdl/riscv_macros.svh */
`ifndef RISCV_MACROS_SVH
`define RISCV_MACROS_SVH

// Datapath widths
`define XLEN        32
`define REG_ADDR_W  5

`define RESET_PC    32'h0000_0000       // First fetch address

// Base opcodes of the supported subset
`define OP_LOAD     7'd3
`define OP_IMM      7'd19
`define OP_STORE    7'd35
`define OP_R        7'd51
`define OP_BRANCH   7'd99
`define OP_JALR     7'd103
`define OP_JAL      7'd111

// ALU control codes
`define ALU_ADD     3'b000
`define ALU_SUB     3'b001
`define ALU_AND     3'b010
`define ALU_OR      3'b011
`define ALU_SLT     3'b101

`endif

/* hdl/riscv_pkg.sv */
`include "riscv_macros.svh"

package riscv_pkg;

    // Data and address word
    typedef logic [`XLEN-1:0]       word_t;

    // Register number from x0 to x31
    typedef logic [`REG_ADDR_W-1:0] reg_idx_t;

    // Raw instruction word
    typedef logic [31:0]            instr_t;

    // Immediate format select
    // 0 = I, 1 = S, 2 = B, 3 = J
    typedef logic [2:0]             imm_src_t;

    // Write-back source
    // 0 = ALU, 1 = memory, 2 = PC+4
    typedef logic [1:0]             result_src_t;

    // Coarse ALU request from the main decoder
    // 0 = add, 1 = sub, 2 = decided by funct fields
    typedef logic [2:0]             alu_op_t;

    // Final ALU operation as one of the ALU_* codes
    typedef logic [2:0]             alu_ctrl_t;

endpackage

/* hdl/alu.sv */
`timescale 1ns/1ps

`include "riscv_macros.svh"

module alu (
    input  riscv_pkg::word_t     a,
    input  riscv_pkg::word_t     b,
    input  riscv_pkg::alu_ctrl_t alu_ctrl,

    output riscv_pkg::word_t     result,
    output logic                 zero
);

    import riscv_pkg::*;

    word_t sum;
    word_t diff;
    logic  lt;

    assign sum  = a + b;
    assign diff = a - b;
    assign lt   = $signed(a) < $signed(b);     // Signed compare for slt

    always_comb begin
        case (alu_ctrl)
            `ALU_ADD: result = sum;
            `ALU_SUB: result = diff;
            `ALU_AND: result = a & b;
            `ALU_OR:  result = a | b;
            `ALU_SLT: result = {{(`XLEN-1){1'b0}}, lt};
            default:  result = '0;
        endcase
    end

    // Branch equality test rides on this
    assign zero = (result == '0);

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/1ps

`include "riscv_macros.svh"

module reg_file (
    input  logic                clk,
    input  logic                rst_n,
    input  riscv_pkg::reg_idx_t rs1_addr,
    input  riscv_pkg::reg_idx_t rs2_addr,
    input  riscv_pkg::reg_idx_t rd_addr,
    input  riscv_pkg::word_t    rd_data,
    input  logic                reg_write,

    output riscv_pkg::word_t    rs1_data,
    output riscv_pkg::word_t    rs2_data
);

    import riscv_pkg::*;

    localparam int NUM_REGS = 1 << `REG_ADDR_W;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_write && (rd_addr != '0)) begin   // x0 stays zero
            regs[rd_addr] <= rd_data;
        end
    end

    // Combinational read ports
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    a_x0_rs1_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (rs1_addr == '0) |-> (rs1_data == '0));
    a_x0_rs2_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (rs2_addr == '0) |-> (rs2_data == '0));

endmodule

/* hdl/imm_extend.sv */
`timescale 1ns/1ps

`include "riscv_macros.svh"

module imm_extend (
    input  riscv_pkg::instr_t   instr,
    input  riscv_pkg::imm_src_t imm_src,

    output riscv_pkg::word_t    imm
);

    always_comb begin
        case (imm_src)
            3'd0: begin                 // I-type
                imm = {{(`XLEN-12){instr[31]}}, instr[31:20]};
            end
            3'd1: begin                 // S-type
                imm = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
            end
            3'd2: begin                 // B-type with halfword offset
                imm = {{(`XLEN-12){instr[31]}}, instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            3'd3: begin                 // J-type
                imm = {{(`XLEN-20){instr[31]}}, instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

/* hdl/main_decoder.sv */
`timescale 1ns/1ps

`include "riscv_macros.svh"

module main_decoder (
    input  logic [6:0]             opcode,
    input  logic                   eq,

    output logic                   pc_src,
    output riscv_pkg::result_src_t result_src,
    output logic                   mem_write,
    output logic                   alu_src,
    output riscv_pkg::imm_src_t    imm_src,
    output logic                   reg_write,
    output riscv_pkg::alu_op_t     alu_op,
    output logic                   jalr
);

    always_comb begin
        // Zero defaults make an unknown opcode a no-op
        pc_src     = 1'b0;
        result_src = 2'd0;
        mem_write  = 1'b0;
        alu_src    = 1'b0;
        imm_src    = 3'd0;
        reg_write  = 1'b0;
        alu_op     = 3'd0;
        jalr       = 1'b0;

        unique case (opcode)
            `OP_R: begin
                reg_write  = 1'b1;
                alu_op     = 3'd2;      // Funct fields pick the op
            end
            `OP_LOAD: begin
                result_src = 2'd1;      // From memory
                alu_src    = 1'b1;
                reg_write  = 1'b1;      // Address is rs1 + I-imm
            end
            `OP_IMM: begin
                alu_src    = 1'b1;
                reg_write  = 1'b1;
                alu_op     = 3'd2;
            end
            `OP_STORE: begin
                mem_write  = 1'b1;
                alu_src    = 1'b1;
                imm_src    = 3'd1;      // S-type
            end
            `OP_BRANCH: begin
                pc_src     = eq;        // Every branch behaves as beq
                imm_src    = 3'd2;      // B-type
                alu_op     = 3'd1;      // Compare by subtraction
            end
            `OP_JALR: begin
                pc_src     = 1'b1;
                result_src = 2'd2;      // Link is PC+4
                alu_src    = 1'b1;      // ALU forms rs1 + imm
                reg_write  = 1'b1;
                jalr       = 1'b1;
            end
            `OP_JAL: begin
                pc_src     = 1'b1;
                result_src = 2'd2;
                imm_src    = 3'd3;      // J-type
                reg_write  = 1'b1;
            end
            default: begin
                // Opcode zero lands here too
            end
        endcase
    end

    // A store never writes the register file in the same instruction
    always_comb begin
        assert #0 (!(mem_write && reg_write))
            else $error("main_decoder: mem_write and reg_write both set, opcode %0d", opcode);
    end

endmodule

/* hdl/control_unit.sv */
`timescale 1ns/1ps

`include "riscv_macros.svh"

module control_unit (
    input  logic [6:0]             opcode,
    input  logic [2:0]             funct3,
    input  logic                   funct7_5,
    input  logic                   zero,

    output logic                   pc_src,
    output logic                   jalr,
    output logic                   mem_write,
    output logic                   alu_src,
    output logic                   reg_write,
    output riscv_pkg::result_src_t result_src,
    output riscv_pkg::imm_src_t    imm_src,
    output riscv_pkg::alu_ctrl_t   alu_ctrl
);

    import riscv_pkg::*;

    alu_op_t alu_op;
    logic    r_sub;                     // Register-form subtract

    main_decoder u_main_decoder (
        .opcode     (opcode),
        .eq         (zero),
        .pc_src     (pc_src),
        .result_src (result_src),
        .mem_write  (mem_write),
        .alu_src    (alu_src),
        .imm_src    (imm_src),
        .reg_write  (reg_write),
        .alu_op     (alu_op),
        .jalr       (jalr)
    );

    // funct7[5] also appears in I-type immediates, so addi must ignore it
    assign r_sub = (opcode == `OP_R) && funct7_5;

    always_comb begin
        unique case (alu_op)
            3'd0: alu_ctrl = `ALU_ADD;
            3'd1: alu_ctrl = `ALU_SUB;
            3'd2: begin
                case (funct3)
                    3'b000:  alu_ctrl = r_sub ? `ALU_SUB : `ALU_ADD;
                    3'b010:  alu_ctrl = `ALU_SLT;
                    3'b110:  alu_ctrl = `ALU_OR;
                    3'b111:  alu_ctrl = `ALU_AND;
                    default: alu_ctrl = `ALU_ADD;   // Unsupported funct3
                endcase
            end
            default: alu_ctrl = `ALU_ADD;
        endcase
    end

    always_comb begin
        assert #0 (alu_ctrl inside {`ALU_ADD, `ALU_SUB, `ALU_AND, `ALU_OR, `ALU_SLT})
            else $error("control_unit: undefined alu_ctrl %0d", alu_ctrl);
    end

endmodule

/* hdl/datapath.sv */
`timescale 1ns/1ps

`include "riscv_macros.svh"

module datapath (
    input  logic                   clk,
    input  logic                   rst_n,
    input  riscv_pkg::instr_t      instr,
    input  riscv_pkg::word_t       read_data,

    input  logic                   pc_src,
    input  logic                   jalr,
    input  logic                   alu_src,
    input  logic                   reg_write,
    input  riscv_pkg::result_src_t result_src,
    input  riscv_pkg::imm_src_t    imm_src,
    input  riscv_pkg::alu_ctrl_t   alu_ctrl,

    output riscv_pkg::word_t       pc,
    output riscv_pkg::word_t       data_addr,
    output riscv_pkg::word_t       write_data,
    output logic                   zero
);

    import riscv_pkg::*;

    reg_idx_t rs1_addr;
    reg_idx_t rs2_addr;
    reg_idx_t rd_addr;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    imm;
    word_t    alu_b;
    word_t    alu_result;
    word_t    result;
    word_t    pc_plus4;
    word_t    pc_target;
    word_t    pc_next;

    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];
    assign rd_addr  = instr[11:7];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    assign pc_plus4  = pc + word_t'(4);
    assign pc_target = pc + imm;                // Branch and jal target

    // jalr target comes out of the ALU as rs1 + imm
    always_comb begin
        if (jalr) begin
            pc_next = {alu_result[`XLEN-1:1], 1'b0};
        end else if (pc_src) begin
            pc_next = pc_target;
        end else begin
            pc_next = pc_plus4;
        end
    end

    reg_file u_reg_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rd_addr   (rd_addr),
        .rd_data   (result),
        .reg_write (reg_write),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data)
    );

    imm_extend u_imm_extend (
        .instr   (instr),
        .imm_src (imm_src),
        .imm     (imm)
    );

    assign alu_b = alu_src ? imm : rs2_data;

    alu u_alu (
        .a        (rs1_data),
        .b        (alu_b),
        .alu_ctrl (alu_ctrl),
        .result   (alu_result),
        .zero     (zero)
    );

    always_comb begin
        case (result_src)
            2'd1:    result = read_data;
            2'd2:    result = pc_plus4;     // Link address
            default: result = alu_result;
        endcase
    end

    assign data_addr  = alu_result;
    assign write_data = rs2_data;

    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00);

endmodule

/* hdl/single_cycle_cpu.sv */
`timescale 1ns/1ps

module single_cycle_cpu (
    input  logic              clk,
    input  logic              rst_n,
    input  riscv_pkg::instr_t instr,
    input  riscv_pkg::word_t  read_data,

    output riscv_pkg::word_t  pc,
    output riscv_pkg::word_t  data_addr,
    output riscv_pkg::word_t  write_data,
    output logic              mem_write
);

    import riscv_pkg::*;

    logic        pc_src;
    logic        jalr;
    logic        alu_src;
    logic        reg_write;
    logic        zero;
    result_src_t result_src;
    imm_src_t    imm_src;
    alu_ctrl_t   alu_ctrl;

    control_unit u_control_unit (
        .opcode     (instr[6:0]),
        .funct3     (instr[14:12]),
        .funct7_5   (instr[30]),
        .zero       (zero),
        .pc_src     (pc_src),
        .jalr       (jalr),
        .mem_write  (mem_write),
        .alu_src    (alu_src),
        .reg_write  (reg_write),
        .result_src (result_src),
        .imm_src    (imm_src),
        .alu_ctrl   (alu_ctrl)
    );

    datapath u_datapath (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr      (instr),
        .read_data  (read_data),
        .pc_src     (pc_src),
        .jalr       (jalr),
        .alu_src    (alu_src),
        .reg_write  (reg_write),
        .result_src (result_src),
        .imm_src    (imm_src),
        .alu_ctrl   (alu_ctrl),
        .pc         (pc),
        .data_addr  (data_addr),
        .write_data (write_data),
        .zero       (zero)
    );

endmodule

/* sim/cpu_tb_program.svh */
`ifndef CPU_TB_PROGRAM_SVH
`define CPU_TB_PROGRAM_SVH

// RAM data section. Words not named here keep the fill pattern
function automatic logic [31:0] ram_preset(input logic [5:0] idx);
    case (idx)
        6'd8:    return 32'h1234_5678;      // Byte address 0x20
        6'd9:    return 32'h8765_4321;      // Byte address 0x24
        default: return ram_fill(idx);
    endcase
endfunction

// Program in address order. x10 holds the store base 0x40
task automatic build_program();
    add_step("addi x1", 32'h00, enc_i(25, 0, 0, 1, OPC_IMM));
    add_step("addi x2 negative", 32'h04, enc_i(-7, 0, 0, 2, OPC_IMM));
    add_step("addi x10", 32'h08, enc_i(64, 0, 0, 10, OPC_IMM));
    add_step("add x3", 32'h0c, enc_r(0, 2, 1, 0, 3));
    add_store("sw add", 32'h10, enc_s(0, 3, 10), 32'h40, 32'h0000_0012);
    add_step("sub x4", 32'h14, enc_r(32, 2, 1, 0, 4));
    add_store("sw sub", 32'h18, enc_s(4, 4, 10), 32'h44, 32'h0000_0020);
    add_step("addi x5", 32'h1c, enc_i(90, 0, 0, 5, OPC_IMM));
    add_step("andi x6", 32'h20, enc_i(15, 5, 7, 6, OPC_IMM));
    add_store("sw andi", 32'h24, enc_s(8, 6, 10), 32'h48, 32'h0000_000a);
    add_step("ori x7", 32'h28, enc_i(768, 5, 6, 7, OPC_IMM));
    add_store("sw ori", 32'h2c, enc_s(12, 7, 10), 32'h4c, 32'h0000_035a);
    add_step("and x8", 32'h30, enc_r(0, 1, 5, 7, 8));
    add_store("sw and", 32'h34, enc_s(16, 8, 10), 32'h50, 32'h0000_0018);
    add_step("or x9", 32'h38, enc_r(0, 1, 5, 6, 9));
    add_store("sw or", 32'h3c, enc_s(20, 9, 10), 32'h54, 32'h0000_005b);
    add_step("slt x11 true", 32'h40, enc_r(0, 1, 2, 2, 11));     // -7 < 25
    add_store("sw slt true", 32'h44, enc_s(24, 11, 10), 32'h58, 32'h0000_0001);
    add_step("slt x11 false", 32'h48, enc_r(0, 2, 1, 2, 11));    // 25 < -7
    add_store("sw slt false", 32'h4c, enc_s(28, 11, 10), 32'h5c, 32'h0000_0000);
    add_step("slti x13", 32'h50, enc_i(-6, 2, 2, 13, OPC_IMM));   // -7 < -6
    add_store("sw slti", 32'h54, enc_s(32, 13, 10), 32'h60, 32'h0000_0001);

    // Loads from the preset words are stored back higher up
    add_step("lw x14", 32'h58, enc_i(-32, 10, 2, 14, OPC_LOAD));
    add_store("sw lw x14", 32'h5c, enc_s(36, 14, 10), 32'h64, 32'h1234_5678);
    add_step("addi x16", 32'h60, enc_i(32, 0, 0, 16, OPC_IMM));
    add_step("lw x15", 32'h64, enc_i(4, 16, 2, 15, OPC_LOAD));
    add_store("sw lw x15", 32'h68, enc_s(40, 15, 10), 32'h68, 32'h8765_4321);

    add_step("beq taken", 32'h6c, enc_b(8, 1, 1));
    add_skipped(32'h70, enc_s(44, 1, 10));
    add_step("beq not taken", 32'h74, enc_b(8, 2, 1));
    add_store("sw after beq", 32'h78, enc_s(44, 1, 10), 32'h6c, 32'h0000_0019);

    add_step("jal x17", 32'h7c, enc_j(12, 17));
    add_skipped(32'h80, enc_s(48, 1, 10));
    add_skipped(32'h84, enc_s(48, 1, 10));
    add_step("addi x18", 32'h88, enc_i(149, 0, 0, 18, OPC_IMM));
    add_step("jalr x19", 32'h8c, enc_i(4, 18, 0, 19, OPC_JALR));  // 0x99 lands on 0x98
    add_skipped(32'h90, enc_s(52, 1, 10));
    add_skipped(32'h94, enc_s(52, 1, 10));
    add_store("sw jal link", 32'h98, enc_s(48, 17, 10), 32'h70, 32'h0000_0080);
    add_store("sw jalr link", 32'h9c, enc_s(52, 19, 10), 32'h74, 32'h0000_0090);

    // No-ops followed by proof that nothing was written
    add_step("opcode zero", 32'ha0, 32'h0000_0000);
    add_step("lui unsupported", 32'ha4, {20'habcde, 5'd20, 7'b0110111});
    add_step("addi x0", 32'ha8, enc_i(123, 0, 0, 0, OPC_IMM));
    add_step("add x0", 32'hac, enc_r(0, 1, 1, 0, 0));
    add_store("sw x0", 32'hb0, enc_s(56, 0, 10), 32'h78, 32'h0000_0000);
    add_store("sw x20", 32'hb4, enc_s(60, 20, 10), 32'h7c, 32'h0000_0000);
endtask

`endif

/* sim/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;

    localparam int OPC_LOAD = 3;
    localparam int OPC_IMM  = 19;
    localparam int OPC_JALR = 103;

    logic        clk;
    logic        rst_n;
    logic [31:0] instr;
    logic [31:0] read_data;
    logic [31:0] pc;
    logic [31:0] data_addr;
    logic [31:0] write_data;
    logic        mem_write;

    logic [31:0] rom [64];
    logic [31:0] ram [64];

    int cycle_count = 0;
    int cycle_limit = 1000;             // Replaced once the table is built

    // Program table columns
    string       step_name  [$];
    logic [31:0] step_pc    [$];
    logic [31:0] step_instr [$];
    bit          step_skip  [$];
    bit          step_store [$];
    logic [31:0] step_addr  [$];
    logic [31:0] step_data  [$];

    single_cycle_cpu dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr      (instr),
        .read_data  (read_data),
        .pc         (pc),
        .data_addr  (data_addr),
        .write_data (write_data),
        .mem_write  (mem_write)
    );

    // Instruction encoders straight from the RV32I formats
    function automatic logic [31:0] enc_r(input int f7, input int rs2, input int rs1,
                                          input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input int imm, input int rs1, input int f3,
                                          input int rd, input int op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] enc_s(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input int imm, input int rs2, input int rs1);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], 3'b000, imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic logic [31:0] ram_fill(input logic [5:0] idx);
        return 32'ha5a5_0000 ^ {24'd0, idx, 2'b00};     // Byte address in the low bits
    endfunction

    task automatic add_entry(input string name, input logic [31:0] at_pc,
                             input logic [31:0] word, input bit skip, input bit store,
                             input logic [31:0] addr, input logic [31:0] data);
        step_name.push_back(name);
        step_pc.push_back(at_pc);
        step_instr.push_back(word);
        step_skip.push_back(skip);
        step_store.push_back(store);
        step_addr.push_back(addr);
        step_data.push_back(data);
    endtask

    task automatic add_step(input string name, input logic [31:0] at_pc,
                            input logic [31:0] word);
        add_entry(name, at_pc, word, 1'b0, 1'b0, 32'h0, 32'h0);
    endtask

    task automatic add_store(input string name, input logic [31:0] at_pc,
                             input logic [31:0] word, input logic [31:0] addr,
                             input logic [31:0] data);
        add_entry(name, at_pc, word, 1'b0, 1'b1, addr, data);
    endtask

    // In ROM only and never reached by the expected pc sequence
    task automatic add_skipped(input logic [31:0] at_pc, input logic [31:0] word);
        add_entry("skipped slot", at_pc, word, 1'b1, 1'b0, 32'h0, 32'h0);
    endtask

    `include "cpu_tb_program.svh"

    task automatic abort_run();
        $display("Test failures found");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected)
        else begin
            $display("[FAIL] %s %s: expected %h, actual %h", name, field, expected, actual);
            abort_run();
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Combinational memories
    assign instr     = rst_n ? rom[pc[7:2]] : 32'h0;    // Zero word during reset
    assign read_data = ram[data_addr[7:2]];

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 64; i++) begin
                ram[i[5:0]] <= ram_preset(i[5:0]);
            end
        end else if (mem_write) begin
            ram[data_addr[7:2]] <= write_data;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the program did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    initial begin
        rst_n = 1'b0;
        build_program();
        cycle_limit = step_name.size() + 30;
        for (int i = 0; i < 64; i++) begin
            rom[i[5:0]] = 32'h0;
        end
        for (int k = 0; k < step_name.size(); k++) begin
            rom[step_pc[k][7:2]] = step_instr[k];
        end

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // One table row per cycle sampled mid-cycle
        for (int k = 0; k < step_name.size(); k++) begin
            if (!step_skip[k]) begin
                @(negedge clk);
                check_value(step_name[k], "pc", step_pc[k], pc);
                check_value(step_name[k], "mem_write", {31'd0, step_store[k]},
                            {31'd0, mem_write});
                if (step_store[k]) begin
                    check_value(step_name[k], "data_addr", step_addr[k], data_addr);
                    check_value(step_name[k], "write_data", step_data[k], write_data);
                end
            end
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

/* single_cycle_cpu.f */
+incdir+hdl
+incdir+sim
hdl/riscv_pkg.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/imm_extend.sv
hdl/main_decoder.sv
hdl/control_unit.sv
hdl/datapath.sv
hdl/single_cycle_cpu.sv
sim/cpu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the CPU testbench with Verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module cpu_tb \
    -f single_cycle_cpu.f \
    -o cpu_tb_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/cpu_tb_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

exit 0
